//--- verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // Sector size of the SD card
    localparam int sd_buf_bytes = 512;

    // Address map
    localparam logic [addr_w-1:0] ram_base       = 64'h0000_0000_0001_0000;
    localparam logic [addr_w-1:0] key_addr       = 64'h0000_0000_0002_0000;
    localparam logic [addr_w-1:0] uart_addr      = 64'h0000_0000_0002_0008;
    localparam logic [addr_w-1:0] sd_sector_addr = 64'h0000_0000_0003_0000;
    localparam logic [addr_w-1:0] sd_read_addr   = 64'h0000_0000_0003_0008;
    localparam logic [addr_w-1:0] sd_ready_addr  = 64'h0000_0000_0003_0010;
    localparam logic [addr_w-1:0] sd_avail_addr  = 64'h0000_0000_0003_0018;
    localparam logic [addr_w-1:0] sd_buf_base    = 64'h0000_0000_0004_0000;

    // Load types, same order as the CPU's funct encoding
    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } load_t;

endpackage

`default_nettype wire

//--- verilog/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric #(
    parameter int ram_words = 1024
) (
    input  wire                          CLOCK_50,
    input  wire                          KEY0,
    input  wire  [soc_pkg::addr_w-1:0]   bus_address,
    input  wire                          bus_read_enable,
    input  wire  soc_pkg::load_t         bus_read_type,
    input  wire                          bus_write_enable,
    input  wire  [soc_pkg::data_w-1:0]   bus_write_data,
    input  wire  [63:0]                  ram_rdata,
    input  wire  [7:0]                   sd_buf_byte,
    input  wire                          sd_avail,
    input  wire                          sd_ready,
    input  wire  [7:0]                   key_ascii,
    output logic [soc_pkg::data_w-1:0]   bus_read_data,
    output logic                         bus_read_done,
    output logic [$clog2(ram_words)-1:0] ram_word_index,
    output logic [1:0]                   ram_lane,
    output logic                         ram_read,
    output logic                         ram_write,
    output logic [31:0]                  ram_wdata,
    output logic [8:0]                   sd_buf_index,
    output logic                         sd_read_pulse,
    output logic [31:0]                  sd_sector,
    output logic                         tx_valid,
    output logic [7:0]                   tx_data
);

    localparam int idx_w = $clog2(ram_words);
    localparam logic [63:0] ram_bytes = 64'(ram_words) * 64'd4;

    logic [63:0] ram_offset;
    logic [63:0] buf_offset;
    logic [63:0] access_span;
    logic        ram_hit_w;
    logic        ram_hit_r;
    logic        buf_hit;
    logic        read_start;
    logic        uart_sel;
    logic        rd_en_d;
    logic        uart_sel_d;
    logic        rd_pending;
    logic        rd_ram_q;
    logic        rd_key_q;
    logic        rd_ready_q;
    logic        rd_avail_q;
    logic        rd_buf_q;
    logic [63:0] read_mux;

    // Bytes touched by a load; ld only sees one 32-bit RAM word
    always_comb begin
        case (bus_read_type)
            soc_pkg::lb, soc_pkg::lbu: access_span = 64'd1;
            soc_pkg::lh, soc_pkg::lhu: access_span = 64'd2;
            default:                   access_span = 64'd4;
        endcase
    end

    assign ram_offset = bus_address - soc_pkg::ram_base;
    assign buf_offset = bus_address - soc_pkg::sd_buf_base;

    // Below-base addresses wrap to a huge offset and miss
    assign ram_hit_w = ram_offset < ram_bytes;
    assign ram_hit_r = ram_hit_w && (ram_offset + access_span <= ram_bytes);
    assign buf_hit   = buf_offset < 64'(soc_pkg::sd_buf_bytes);

    // Only the first sampled cycle of a held enable starts a read
    assign read_start = bus_read_enable && !rd_en_d;

    assign ram_word_index = ram_offset[idx_w+1:2];
    assign ram_lane       = bus_address[1:0];
    assign ram_read       = read_start && ram_hit_r;
    assign ram_write      = bus_write_enable && ram_hit_w;
    assign ram_wdata      = bus_write_data[31:0];
    assign sd_buf_index   = buf_offset[8:0];

    assign uart_sel = bus_write_enable && (bus_address == soc_pkg::uart_addr);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_en_d       <= 1'b0;
            rd_pending    <= 1'b0;
            rd_ram_q      <= 1'b0;
            rd_key_q      <= 1'b0;
            rd_ready_q    <= 1'b0;
            rd_avail_q    <= 1'b0;
            rd_buf_q      <= 1'b0;
            bus_read_done <= 1'b0;
        end else begin
            rd_en_d       <= bus_read_enable;
            rd_pending    <= read_start;
            rd_ram_q      <= read_start && ram_hit_r;
            rd_key_q      <= read_start && (bus_address == soc_pkg::key_addr);
            rd_ready_q    <= read_start && (bus_address == soc_pkg::sd_ready_addr);
            rd_avail_q    <= read_start && (bus_address == soc_pkg::sd_avail_addr);
            rd_buf_q      <= read_start && buf_hit;
            bus_read_done <= rd_pending;
        end
    end

    // Second cycle of a read picks the answer of the registered target
    always_comb begin
        read_mux = 64'd0;
        if (rd_ram_q)   read_mux = ram_rdata;
        if (rd_key_q)   read_mux = {56'd0, key_ascii};
        if (rd_ready_q) read_mux = {63'd0, sd_ready};
        if (rd_avail_q) read_mux = {63'd0, sd_avail};
        if (rd_buf_q)   read_mux = {56'd0, sd_buf_byte};
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_pending) begin
            bus_read_data <= read_mux;
        end
    end

    // Sector number, read command and UART strobe
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_sector     <= 32'd0;
            sd_read_pulse <= 1'b0;
            uart_sel_d    <= 1'b0;
            tx_valid      <= 1'b0;
        end else begin
            if (bus_write_enable && (bus_address == soc_pkg::sd_sector_addr)) begin
                sd_sector <= bus_write_data[31:0];
            end
            sd_read_pulse <= bus_write_enable && (bus_address == soc_pkg::sd_read_addr);
            uart_sel_d    <= uart_sel;
            tx_valid      <= uart_sel && !uart_sel_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_sel && !uart_sel_d) begin
            tx_data <= bus_write_data[7:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ram_words = 1024
) (
    input  wire                          CLOCK_50,
    input  wire  [$clog2(ram_words)-1:0] ram_word_index,
    input  wire  [1:0]                   ram_lane,
    input  wire  soc_pkg::load_t         bus_read_type,
    input  wire                          ram_read,
    input  wire                          ram_write,
    input  wire  [31:0]                  ram_wdata,
    output logic [63:0]                  ram_rdata
);

    logic [31:0]    mem [ram_words];
    logic [31:0]    word_q;
    logic [1:0]     lane_q;
    soc_pkg::load_t type_q;
    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;

    always_ff @(posedge CLOCK_50) begin
        if (ram_write) begin
            mem[ram_word_index] <= ram_wdata;
        end
        // Lane and type travel with the word they belong to
        if (ram_read) begin
            word_q <= mem[ram_word_index];
            lane_q <= ram_lane;
            type_q <= bus_read_type;
        end
    end

    always_comb begin
        case (lane_q)
            2'd0:    byte_sel = word_q[7:0];
            2'd1:    byte_sel = word_q[15:8];
            2'd2:    byte_sel = word_q[23:16];
            default: byte_sel = word_q[31:24];
        endcase
    end

    // Upper half when lane bit 1 is set
    assign half_sel = lane_q[1] ? word_q[31:16] : word_q[15:0];

    always_comb begin
        case (type_q)
            soc_pkg::lb:  ram_rdata = {{56{byte_sel[7]}}, byte_sel};
            soc_pkg::lbu: ram_rdata = {56'd0, byte_sel};
            soc_pkg::lh:  ram_rdata = {{48{half_sel[15]}}, half_sel};
            soc_pkg::lhu: ram_rdata = {48'd0, half_sel};
            soc_pkg::lw:  ram_rdata = {{32{word_q[31]}}, word_q};
            // lwu, and ld which only has one word behind it
            default:      ram_rdata = {32'd0, word_q};
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/sd_sector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_sector_buffer (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire  [7:0] sd_byte,
    input  wire        sd_byte_valid,
    input  wire        sd_read_pulse,
    input  wire  [8:0] sd_buf_index,
    output logic [7:0] sd_buf_byte,
    output logic       sd_avail
);

    localparam int idx_w = $clog2(soc_pkg::sd_buf_bytes);

    logic [7:0]     sector_mem [soc_pkg::sd_buf_bytes];
    logic [idx_w:0] byte_index;
    logic           valid_d;
    logic           byte_strobe;

    // One store per rising edge of the controller's byte flag
    assign byte_strobe = sd_byte_valid && !valid_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            valid_d    <= 1'b0;
            byte_index <= '0;
            sd_avail   <= 1'b0;
        end else begin
            valid_d <= sd_byte_valid;
            if (sd_read_pulse) begin
                // New sector requested, start over
                byte_index <= '0;
                sd_avail   <= 1'b0;
            end else if (byte_index == (idx_w + 1)'(soc_pkg::sd_buf_bytes)) begin
                byte_index <= '0;
                sd_avail   <= 1'b1;
            end else if (byte_strobe) begin
                byte_index <= byte_index + 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_strobe && !sd_read_pulse && !byte_index[idx_w]) begin
            sector_mem[byte_index[idx_w-1:0]] <= sd_byte;
        end
    end

    // Bus side read port
    always_ff @(posedge CLOCK_50) begin
        sd_buf_byte <= sector_mem[sd_buf_index];
    end

endmodule

`default_nettype wire

//--- verilog/keyboard_irq.sv
`timescale 1ns/1ps
`default_nettype none

module keyboard_irq (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire        key_valid,
    input  wire  [7:0] key_ascii_in,
    input  wire        irq_ack,
    output logic [7:0] key_ascii,
    output logic       irq
);

    logic key_hit;

    // Keys without an ASCII code are ignored
    assign key_hit = key_valid && (key_ascii_in != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_ascii <= 8'd0;
        end else if (key_hit) begin
            key_ascii <= key_ascii_in;
        end
    end

    // Single interrupt source
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq <= 1'b0;
        end else if (key_hit) begin
            // A fresh key beats a pending acknowledge
            irq <= 1'b1;
        end else if (irq && irq_ack) begin
            irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/soc_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
    parameter int ram_words = 1024
) (
    input  wire                        CLOCK_50,
    input  wire                        KEY0,
    input  wire  [soc_pkg::addr_w-1:0] bus_address,
    input  wire                        bus_read_enable,
    input  wire  soc_pkg::load_t       bus_read_type,
    input  wire                        bus_write_enable,
    input  wire  [soc_pkg::data_w-1:0] bus_write_data,
    output logic [soc_pkg::data_w-1:0] bus_read_data,
    output logic                       bus_read_done,
    input  wire                        key_valid,
    input  wire  [7:0]                 key_ascii_in,
    output logic                       irq,
    input  wire                        irq_ack,
    output logic                       sd_rd_start,
    output logic [31:0]                sd_sector,
    input  wire  [7:0]                 sd_byte,
    input  wire                        sd_byte_valid,
    input  wire                        sd_ready,
    output logic                       tx_valid,
    output logic [7:0]                 tx_data
);

    logic [$clog2(ram_words)-1:0] ram_word_index;
    logic [1:0]                   ram_lane;
    logic                         ram_read;
    logic                         ram_write;
    logic [31:0]                  ram_wdata;
    logic [63:0]                  ram_rdata;
    logic [8:0]                   sd_buf_index;
    logic [7:0]                   sd_buf_byte;
    logic                         sd_avail;
    logic [7:0]                   key_ascii;

    bus_fabric #(
        .ram_words(ram_words)
    ) u_fabric (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_read_enable (bus_read_enable),
        .bus_read_type   (bus_read_type),
        .bus_write_enable(bus_write_enable),
        .bus_write_data  (bus_write_data),
        .ram_rdata       (ram_rdata),
        .sd_buf_byte     (sd_buf_byte),
        .sd_avail        (sd_avail),
        .sd_ready        (sd_ready),
        .key_ascii       (key_ascii),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done),
        .ram_word_index  (ram_word_index),
        .ram_lane        (ram_lane),
        .ram_read        (ram_read),
        .ram_write       (ram_write),
        .ram_wdata       (ram_wdata),
        .sd_buf_index    (sd_buf_index),
        .sd_read_pulse   (sd_rd_start),
        .sd_sector       (sd_sector),
        .tx_valid        (tx_valid),
        .tx_data         (tx_data)
    );

    data_ram #(
        .ram_words(ram_words)
    ) u_ram (
        .CLOCK_50      (CLOCK_50),
        .ram_word_index(ram_word_index),
        .ram_lane      (ram_lane),
        .bus_read_type (bus_read_type),
        .ram_read      (ram_read),
        .ram_write     (ram_write),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata)
    );

    // Same read pulse restarts the buffer and goes out to the controller
    sd_sector_buffer u_sd_buf (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .sd_byte      (sd_byte),
        .sd_byte_valid(sd_byte_valid),
        .sd_read_pulse(sd_rd_start),
        .sd_buf_index (sd_buf_index),
        .sd_buf_byte  (sd_buf_byte),
        .sd_avail     (sd_avail)
    );

    keyboard_irq u_kbd (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_valid   (key_valid),
        .key_ascii_in(key_ascii_in),
        .irq_ack     (irq_ack),
        .key_ascii   (key_ascii),
        .irq         (irq)
    );

endmodule

`default_nettype wire

//--- test/soc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module soc_assert (
    input wire CLOCK_50,
    input wire KEY0,
    input wire bus_read_done,
    input wire tx_valid,
    input wire irq,
    input wire irq_ack
);

    int unsigned failures = 0;

    // Done is a single-cycle pulse per read
    done_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done |=> !bus_read_done)
    else begin
        failures++;
        $error("bus_read_done high in two consecutive cycles");
    end

    // One transmit strobe per write, even a held one
    tx_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_valid |=> !tx_valid)
    else begin
        failures++;
        $error("tx_valid high in two consecutive cycles");
    end

    // Only an acknowledge takes the interrupt down
    irq_fall_on_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(irq) |-> $past(irq_ack))
    else begin
        failures++;
        $error("irq fell without a preceding irq_ack");
    end

endmodule

`default_nettype wire

//--- test/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

    localparam int ram_words = 1024;
    localparam int read_latency = 2;
    // About four times the length of all tests
    localparam int test_cycles = 3000;
    localparam int timeout_cycles = 4 * test_cycles;

    logic           CLOCK_50;
    logic           KEY0;
    logic [63:0]    bus_address;
    logic           bus_read_enable;
    soc_pkg::load_t bus_read_type;
    logic           bus_write_enable;
    logic [63:0]    bus_write_data;
    logic [63:0]    bus_read_data;
    logic           bus_read_done;
    logic           key_valid;
    logic [7:0]     key_ascii_in;
    logic           irq;
    logic           irq_ack;
    logic           sd_rd_start;
    logic [31:0]    sd_sector;
    logic [7:0]     sd_byte;
    logic           sd_byte_valid;
    logic           sd_ready;
    logic           tx_valid;
    logic [7:0]     tx_data;

    logic [31:0] lfsr_state = 32'h83a71a1a;
    int          cycle_count = 0;
    int          tx_count = 0;
    int          rd_start_count = 0;
    logic [7:0]  tx_last;
    logic [7:0]  sector_bytes [512];

    soc_periph_top #(
        .ram_words(ram_words)
    ) DUT (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_read_enable (bus_read_enable),
        .bus_read_type   (bus_read_type),
        .bus_write_enable(bus_write_enable),
        .bus_write_data  (bus_write_data),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done),
        .key_valid       (key_valid),
        .key_ascii_in    (key_ascii_in),
        .irq             (irq),
        .irq_ack         (irq_ack),
        .sd_rd_start     (sd_rd_start),
        .sd_sector       (sd_sector),
        .sd_byte         (sd_byte),
        .sd_byte_valid   (sd_byte_valid),
        .sd_ready        (sd_ready),
        .tx_valid        (tx_valid),
        .tx_data         (tx_data)
    );

    bind soc_periph_top soc_assert u_assert (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bus_read_done(bus_read_done),
        .tx_valid     (tx_valid),
        .irq          (irq),
        .irq_ack      (irq_ack)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #2 CLOCK_50 = ~CLOCK_50;
        end
    end

    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests still running after %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // Pulse counters for the UART strobe and the SD read command
    always @(posedge CLOCK_50) begin
        if (tx_valid) begin
            tx_count++;
            tx_last = tx_data;
        end
        if (sd_rd_start) begin
            rd_start_count++;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write_held(input logic [63:0] address, input logic [63:0] data,
                                  input int cycles);
        @(negedge CLOCK_50);
        bus_address = address;
        bus_write_data = data;
        bus_write_enable = 1'b1;
        repeat (cycles) @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
    endtask

    task automatic bus_write(input logic [63:0] address, input logic [63:0] data);
        bus_write_held(address, data, 1);
    endtask

    task automatic bus_read(input logic [63:0] address, input soc_pkg::load_t kind,
                            input logic [63:0] expected, input string what);
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        bus_address = address;
        bus_read_type = kind;
        bus_read_enable = 1'b1;
        while (!bus_read_done && waited < 16) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!bus_read_done) begin
            $display("Read of address 0x%0h never signalled done", address);
            $display("Simulation finished: FAIL");
            $fatal(1, "missing read done");
        end
        check_equal(64'(waited), 64'(read_latency), {what, " latency"});
        check_equal(bus_read_data, expected, what);
        bus_read_enable = 1'b0;
    endtask

    task automatic press_key(input logic [7:0] code);
        @(negedge CLOCK_50);
        key_ascii_in = code;
        key_valid = 1'b1;
        @(negedge CLOCK_50);
        key_valid = 1'b0;
    endtask

    task automatic acknowledge_irq();
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
    endtask

    task automatic test_reset_and_unmapped();
        check_equal(64'(irq), 64'd0, "irq after reset");
        check_equal(64'(tx_valid), 64'd0, "tx_valid after reset");
        check_equal(64'(sd_rd_start), 64'd0, "sd_rd_start after reset");
        check_equal(64'(bus_read_done), 64'd0, "bus_read_done after reset");
        check_equal(64'(sd_sector), 64'd0, "sector register after reset");
        bus_read(64'h0000_0000_0005_0000, soc_pkg::lw, 64'd0, "unmapped read");
        bus_read(64'h0000_0000_0000_0100, soc_pkg::ld, 64'd0, "read below RAM");
        bus_read(soc_pkg::ram_base + 64'(4 * ram_words), soc_pkg::lbu, 64'd0,
                 "read past RAM end");
    endtask

    task automatic test_ram_words();
        logic [31:0] words [6];
        logic [63:0] address;
        int          i;
        for (i = 0; i < 6; i++) begin
            words[i] = random_bits(32);
            // Alternate the sign bit so both extensions show up
            words[i][31] = i[0];
            address = soc_pkg::ram_base + 64'(4 * ((i == 5) ? ram_words - 1 : i * 203));
            bus_write(address, {random_bits(32), words[i]});
        end
        for (i = 0; i < 6; i++) begin
            address = soc_pkg::ram_base + 64'(4 * ((i == 5) ? ram_words - 1 : i * 203));
            bus_read(address, soc_pkg::lw, 64'($signed(words[i])), "lw word");
            bus_read(address, soc_pkg::lwu, {32'd0, words[i]}, "lwu word");
            bus_read(address, soc_pkg::ld, {32'd0, words[i]}, "ld word");
        end
    endtask

    task automatic test_sized_loads();
        logic [31:0] word;
        logic [63:0] address;
        logic [7:0]  part8;
        logic [15:0] part16;
        int          round;
        int          lane;
        address = soc_pkg::ram_base + 64'd160;
        for (round = 0; round < 2; round++) begin
            word = (round == 0) ? 32'h7f81_80ff : random_bits(32);
            bus_write(address, 64'(word));
            for (lane = 0; lane < 4; lane++) begin
                part8 = word[8*lane +: 8];
                bus_read(address + 64'(lane), soc_pkg::lb, 64'($signed(part8)), "lb lane");
                bus_read(address + 64'(lane), soc_pkg::lbu, 64'(part8), "lbu lane");
            end
            for (lane = 0; lane < 2; lane++) begin
                part16 = word[16*lane +: 16];
                bus_read(address + 64'(2 * lane), soc_pkg::lh, 64'($signed(part16)), "lh half");
                bus_read(address + 64'(2 * lane), soc_pkg::lhu, 64'(part16), "lhu half");
            end
        end
    endtask

    task automatic test_keyboard();
        logic [7:0] code;
        code = 8'(random_bits(7));
        if (code == 8'd0) begin
            code = 8'h61;
        end
        press_key(code);
        check_equal(64'(irq), 64'd1, "irq after key");
        bus_read(soc_pkg::key_addr, soc_pkg::lbu, 64'(code), "key register");
        acknowledge_irq();
        check_equal(64'(irq), 64'd0, "irq after acknowledge");
        // Zero code is not a key and leaves the register alone
        press_key(8'd0);
        check_equal(64'(irq), 64'd0, "irq after zero code");
        bus_read(soc_pkg::key_addr, soc_pkg::lbu, 64'(code), "key register after zero code");
        press_key(8'h5a);
        press_key(8'h31);
        check_equal(64'(irq), 64'd1, "irq after two keys");
        bus_read(soc_pkg::key_addr, soc_pkg::lbu, 64'h31, "key register after two keys");
        acknowledge_irq();
        check_equal(64'(irq), 64'd0, "irq after second acknowledge");
    endtask

    task automatic test_sd_sector();
        logic [31:0] sector;
        int          starts_before;
        int          index;
        int          n;
        sector = random_bits(32);
        bus_write(soc_pkg::sd_sector_addr, 64'(sector));
        starts_before = rd_start_count;
        bus_write(soc_pkg::sd_read_addr, 64'd1);
        repeat (3) @(negedge CLOCK_50);
        check_equal(64'(rd_start_count - starts_before), 64'd1, "sd_rd_start pulses");
        check_equal(64'(sd_sector), 64'(sector), "sd_sector");
        bus_read(soc_pkg::sd_ready_addr, soc_pkg::ld, 64'd0, "sd ready low");
        sd_ready = 1'b1;
        bus_read(soc_pkg::sd_ready_addr, soc_pkg::ld, 64'd1, "sd ready high");
        bus_read(soc_pkg::sd_avail_addr, soc_pkg::ld, 64'd0, "sd avail before data");
        for (index = 0; index < soc_pkg::sd_buf_bytes; index++) begin
            sector_bytes[index] = 8'(random_bits(8));
            @(negedge CLOCK_50);
            sd_byte = sector_bytes[index];
            sd_byte_valid = 1'b1;
            @(negedge CLOCK_50);
            sd_byte_valid = 1'b0;
        end
        bus_read(soc_pkg::sd_avail_addr, soc_pkg::ld, 64'd1, "sd avail after sector");
        for (n = 0; n < 10; n++) begin
            case (n)
                0: index = 0;
                1: index = 1;
                2: index = 255;
                3: index = 256;
                4: index = 511;
                default: index = int'(random_bits(9));
            endcase
            bus_read(soc_pkg::sd_buf_base + 64'(index), soc_pkg::lbu,
                     64'(sector_bytes[index]), "sector buffer byte");
        end
        check_equal(64'(rd_start_count - starts_before), 64'd1, "no extra sd_rd_start");
        // A new command drops the flag until the next sector is in
        bus_write(soc_pkg::sd_read_addr, 64'd1);
        bus_read(soc_pkg::sd_avail_addr, soc_pkg::ld, 64'd0, "sd avail after new command");
        check_equal(64'(rd_start_count - starts_before), 64'd2, "second sd_rd_start");
    endtask

    task automatic test_uart();
        logic [63:0] data;
        int          count_before;
        data = {random_bits(32), random_bits(32)};
        count_before = tx_count;
        bus_write(soc_pkg::uart_addr, data);
        repeat (3) @(negedge CLOCK_50);
        check_equal(64'(tx_count - count_before), 64'd1, "tx pulses for one write");
        check_equal(64'(tx_last), 64'(data[7:0]), "tx byte");
        data = {random_bits(32), random_bits(32)};
        count_before = tx_count;
        bus_write_held(soc_pkg::uart_addr, data, 3);
        repeat (3) @(negedge CLOCK_50);
        check_equal(64'(tx_count - count_before), 64'd1, "tx pulses for held write");
        check_equal(64'(tx_last), 64'(data[7:0]), "tx byte of held write");
    endtask

    initial begin
        KEY0 = 1'b0;
        bus_address = '0;
        bus_read_enable = 1'b0;
        bus_read_type = soc_pkg::lw;
        bus_write_enable = 1'b0;
        bus_write_data = '0;
        key_valid = 1'b0;
        key_ascii_in = 8'd0;
        irq_ack = 1'b0;
        sd_byte = 8'd0;
        sd_byte_valid = 1'b0;
        sd_ready = 1'b0;
        repeat (16) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        test_reset_and_unmapped();
        test_ram_words();
        test_sized_loads();
        test_keyboard();
        test_sd_sector();
        test_uart();
        repeat (4) @(negedge CLOCK_50);
        if (DUT.u_assert.failures == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

//--- all.f
verilog/soc_pkg.sv
verilog/bus_fabric.sv
verilog/data_ram.sv
verilog/sd_sector_buffer.sv
verilog/keyboard_irq.sv
verilog/soc_periph_top.sv
test/soc_assert.sv
test/tb_soc.sv

//--- Makefile
# Verilator run of the peripheral testbench
TOP = tb_soc
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
